// File: list.f
design/dma_cfg_pkg.sv
design/axi_pkg.sv
design/sync_fifo.sv
design/beat_counter.sv
design/axi_write_issuer.sv
design/write_resp_tracker.sv
design/dma_write_top.sv
bench/dma_write_asserts.sv
bench/dma_write_tb.sv

// File: bench/dma_write_tb.sv
/*
  Testbench for the DMA write engine with an AXI4 slave memory model.
  The model holds 4 KB; bursts starting in the error window get SLVERR.
  Slave stalls on awready, wready and bvalid are random.
*/

`timescale 1ns/1ps
`default_nettype none

module dma_write_tb;

  localparam int addr_w    = 32;
  localparam int bus_w     = 64;
  localparam int sample_w  = 32;
  localparam int len_w     = dma_cfg_pkg::len_w;
  localparam int strb_w    = bus_w / 8;
  localparam int smp_bytes = sample_w / 8;
  localparam int mem_bytes = 4096;

  localparam logic [addr_w-1:0] err_lo    = 32'h0000_0c00;
  localparam logic [addr_w-1:0] err_hi    = 32'h0000_0fff;
  localparam logic [strb_w-1:0] lane_strb = strb_w'((1 << smp_bytes) - 1);

  typedef struct packed {
    logic [addr_w-1:0]   addr;
    logic [len_w-1:0]    len;
    logic [sample_w-1:0] first;
    logic                err;
  } entry_t;

  logic                clk;
  logic                rst_n;
  logic                flush;
  logic                cmd_valid;
  logic                cmd_ready;
  logic [addr_w-1:0]   cmd_addr;
  logic [len_w-1:0]    cmd_len;
  logic                data_valid;
  logic                data_ready;
  logic [sample_w-1:0] data;
  logic                awvalid;
  logic                awready;
  logic [addr_w-1:0]   awaddr;
  logic [len_w-1:0]    awlen;
  logic [2:0]          awsize;
  logic [1:0]          awburst;
  logic                wvalid;
  logic                wready;
  logic [bus_w-1:0]    wdata;
  logic [strb_w-1:0]   wstrb;
  logic                wlast;
  logic                bvalid;
  logic                bready;
  logic [1:0]          bresp;
  logic                burst_done;
  logic                burst_error;
  logic                idle;

  entry_t            tbl [$];
  logic [7:0]        mem [mem_bytes];
  logic [7:0]        exp_mem [mem_bytes];
  logic [addr_w-1:0] aw_addr_q [$];
  logic [len_w-1:0]  aw_len_q [$];
  logic [1:0]        b_resp_q [$];
  int                beat_idx = 0;
  int                aw_count = 0;
  int                w_count = 0;
  int                done_count = 0;
  int                err_count = 0;
  int                total_beats = 0;
  int                exp_errors = 0;
  logic              tbl_built = 1'b0;
  logic              cmds_sent = 1'b0;
  integer            seed = 32'h564b_27a9;

  dma_write_top #(
    .addr_w          (addr_w),
    .bus_w           (bus_w),
    .sample_w        (sample_w),
    .cmd_depth       (4),
    .data_depth      (16),
    .max_outstanding (4)
  ) uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .cmd_addr    (cmd_addr),
    .cmd_len     (cmd_len),
    .data_valid  (data_valid),
    .data_ready  (data_ready),
    .data        (data),
    .awvalid     (awvalid),
    .awready     (awready),
    .awaddr      (awaddr),
    .awlen       (awlen),
    .awsize      (awsize),
    .awburst     (awburst),
    .wvalid      (wvalid),
    .wready      (wready),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .wlast       (wlast),
    .bvalid      (bvalid),
    .bready      (bready),
    .bresp       (bresp),
    .burst_done  (burst_done),
    .burst_error (burst_error),
    .idle        (idle)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("FAIL %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // Background pattern of the memory model
  function automatic logic [7:0] fill_byte(input int unsigned a);
    return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
  endfunction

  function automatic logic in_err_window(input logic [addr_w-1:0] a);
    return (a >= err_lo) && (a <= err_hi);
  endfunction

  function automatic void add_entry(input logic [addr_w-1:0] addr, input logic [len_w-1:0] len,
                                    input logic [sample_w-1:0] first, input logic err);
    entry_t e;
    e.addr  = addr;
    e.len   = len;
    e.first = first;
    e.err   = err;
    tbl.push_back(e);
  endfunction

  task automatic send_commands();
    for (int i = 0; i < tbl.size(); i++)
    begin
      cmd_valid <= 1'b1;
      cmd_addr  <= tbl[i].addr;
      cmd_len   <= tbl[i].len;
      @(posedge clk);
      while (!cmd_ready)
        @(posedge clk);
    end
    cmd_valid <= 1'b0;
    cmds_sent <= 1'b1;
  endtask

  // Sample value is the entry's first value plus the beat index
  task automatic send_samples();
    for (int i = 0; i < tbl.size(); i++)
    begin
      for (int j = 0; j <= int'(tbl[i].len); j++)
      begin
        data_valid <= 1'b1;
        data       <= tbl[i].first + sample_w'(j);
        @(posedge clk);
        while (!data_ready)
          @(posedge clk);
      end
    end
    data_valid <= 1'b0;
  endtask

  // ****************************************
  // AXI slave memory model and monitors
  // ****************************************
  always @(posedge clk)
  begin
    logic [addr_w-1:0] beat_addr;
    logic [addr_w-1:0] word_base;
    if (rst_n)
    begin
      if (awvalid && awready)
      begin
        check_value(aw_count < tbl.size(), 1, "AW beyond the command table");
        check_value(awaddr, tbl[aw_count].addr, "AW address in table order");
        check_value(awlen, tbl[aw_count].len, "AW length");
        check_value(awsize, 3'd2, "AW size for 4-byte samples");
        check_value(awburst, 2'b01, "AW burst type INCR");
        aw_addr_q.push_back(awaddr);
        aw_len_q.push_back(awlen);
        aw_count++;
      end
      if (wvalid && wready)
      begin
        check_value(aw_addr_q.size() != 0, 1, "W beat without an accepted AW");
        beat_addr = aw_addr_q[0] + addr_w'(beat_idx * smp_bytes);
        word_base = beat_addr & ~addr_w'(strb_w - 1);
        check_value(wstrb, lane_strb << (beat_addr % strb_w), "write strobe lane");
        check_value(wlast, beat_idx == int'(aw_len_q[0]), "wlast position");
        for (int b = 0; b < strb_w; b++)
          if (wstrb[b])
            mem[word_base + b] = wdata[8*b +: 8];
        w_count++;
        if (wlast)
        begin
          b_resp_q.push_back(in_err_window(aw_addr_q[0]) ? axi_pkg::resp_slverr
                                                          : axi_pkg::resp_okay);
          void'(aw_addr_q.pop_front());
          void'(aw_len_q.pop_front());
          beat_idx = 0;
        end
        else
          beat_idx++;
      end
      if (bvalid && bready)
        void'(b_resp_q.pop_front());
      if (burst_done)
      begin
        check_value(burst_error, tbl[done_count].err, "burst_error of completed burst");
        if (burst_error)
          err_count++;
        done_count++;
      end
      else
        check_value(burst_error, 1'b0, "burst_error without burst_done");
      if (cmds_sent && idle)
        check_value(done_count, tbl.size(), "idle before the last burst_done");
      // Random stalls for the next cycle and B held until taken
      awready <= ($random(seed) & 3) != 0;
      wready  <= ($random(seed) & 3) != 0;
      if (bvalid && !bready)
        bvalid <= 1'b1;
      else if (b_resp_q.size() != 0 && (($random(seed) & 3) != 0))
      begin
        bvalid <= 1'b1;
        bresp  <= b_resp_q[0];
      end
      else
        bvalid <= 1'b0;
    end
  end

  initial
  begin
    int limit;
    wait (tbl_built);
    limit = total_beats * 40 + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    $display("Simulation failed");
    $fatal(1);
  end

  initial
  begin
    logic [addr_w-1:0]   a;
    logic [sample_w-1:0] smp;
    rst_n = 1'b0;
    flush = 1'b0;
    cmd_valid = 1'b0;
    cmd_addr = '0;
    cmd_len = '0;
    data_valid = 1'b0;
    data = '0;
    awready = 1'b0;
    wready = 1'b0;
    bvalid = 1'b0;
    bresp = '0;
    // Address, length, first sample, in error window
    add_entry(32'h0000_0104, 8'd0,  32'ha1b2_c3d4, 1'b0);
    add_entry(32'h0000_0200, 8'd15, 32'h1000_0000, 1'b0);
    add_entry(32'h0000_0300, 8'd3,  32'h2222_0000, 1'b0);
    add_entry(32'h0000_0c08, 8'd1,  32'h3333_0000, 1'b1);
    add_entry(32'h0000_040c, 8'd6,  32'h4444_0000, 1'b0);
    add_entry(32'h0000_0500, 8'd0,  32'h5555_0000, 1'b0);
    add_entry(32'h0000_0d04, 8'd7,  32'h6666_0000, 1'b1);
    add_entry(32'h0000_0610, 8'd2,  32'h7777_0000, 1'b0);
    add_entry(32'h0000_0800, 8'd15, 32'h8888_0000, 1'b0);
    for (int i = 0; i < mem_bytes; i++)
    begin
      mem[i]     = fill_byte(i);
      exp_mem[i] = fill_byte(i);
    end
    // Expected image holds little-endian samples at consecutive locations
    for (int i = 0; i < tbl.size(); i++)
    begin
      for (int j = 0; j <= int'(tbl[i].len); j++)
      begin
        a   = tbl[i].addr + addr_w'(j * smp_bytes);
        smp = tbl[i].first + sample_w'(j);
        for (int k = 0; k < smp_bytes; k++)
          exp_mem[a + k] = smp[8*k +: 8];
      end
      total_beats += int'(tbl[i].len) + 1;
      if (tbl[i].err)
        exp_errors++;
    end
    tbl_built = 1'b1;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_value(idle, 1'b1, "idle after reset");
    check_value({awvalid, wvalid, bready, burst_done, burst_error}, '0, "outputs after reset");
    fork
      send_commands();
      send_samples();
    join
    wait (done_count == tbl.size());
    @(posedge clk);
    check_value(idle, 1'b1, "idle after all responses");
    check_value(err_count, exp_errors, "burst_error count");
    check_value(w_count, total_beats, "total W handshakes");
    check_value(aw_addr_q.size() + b_resp_q.size(), 0, "bursts left open in the slave");
    for (int i = 0; i < mem_bytes; i++)
      check_value(mem[i], exp_mem[i], $sformatf("memory byte at 0x%0h", i));
    if (uut.protocol_checks.violations == 0)
    begin
      $display("Simulation passed");
      $finish;
    end
    else
    begin
      $display("Protocol assertions failed %0d times", uut.protocol_checks.violations);
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// File: bench/dma_write_asserts.sv
/*
  AXI4 write protocol checks, bound into the DMA write top.
  Assumes the W beats of a burst follow its own AW before the next AW,
  which is how this master issues them.
*/

`timescale 1ns/1ps
`default_nettype none

module dma_write_asserts #(
  parameter int addr_w = 32,
  parameter int bus_w  = 64
) (
  input wire                            clk,
  input wire                            rst_n,
  input wire                            awvalid,
  input wire                            awready,
  input wire [addr_w-1:0]               awaddr,
  input wire [dma_cfg_pkg::len_w-1:0]   awlen,
  input wire                            wvalid,
  input wire                            wready,
  input wire [bus_w-1:0]                wdata,
  input wire [bus_w/8-1:0]              wstrb,
  input wire                            wlast
);

  int violations = 0;

  logic [dma_cfg_pkg::len_w-1:0] burst_len;
  logic [dma_cfg_pkg::len_w-1:0] beat_no;
  logic                          aw_open;

  // Length and beat position of the burst in its data phase
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      burst_len <= '0;
      beat_no   <= '0;
      aw_open   <= 1'b0;
    end
    else
    begin
      if (awvalid && awready)
      begin
        burst_len <= awlen;
        aw_open   <= 1'b1;
      end
      else if (wvalid && wready && wlast)
        aw_open <= 1'b0;
      if (wvalid && wready)
        beat_no <= wlast ? '0 : beat_no + 1'b1;
    end
  end

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
  else
  begin
    $error("AW request dropped or changed before awready");
    violations++;
  end

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb) && $stable(wlast))
  else
  begin
    $error("W beat dropped or changed before wready");
    violations++;
  end

  w_last_pos: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid |-> (wlast == (beat_no == burst_len)))
  else
  begin
    $error("wlast not on beat awlen");
    violations++;
  end

  w_after_aw: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid |-> aw_open)
  else
  begin
    $error("W beat without a preceding AW handshake");
    violations++;
  end

endmodule

bind dma_write_top dma_write_asserts #(
  .addr_w (addr_w),
  .bus_w  (bus_w)
) protocol_checks (
  .clk     (clk),
  .rst_n   (rst_n),
  .awvalid (awvalid),
  .awready (awready),
  .awaddr  (awaddr),
  .awlen   (awlen),
  .wvalid  (wvalid),
  .wready  (wready),
  .wdata   (wdata),
  .wstrb   (wstrb),
  .wlast   (wlast)
);

`default_nettype wire

// File: design/dma_write_top.sv
/*
  DMA write engine top. One AXI4 INCR write burst per command.
  Commands must not cross a 4 KB page and must be aligned to the sample.
  flush empties both FIFOs and is meant for use while idle.
*/

`timescale 1ns/1ps
`default_nettype none

module dma_write_top #(
  parameter int addr_w          = 32,
  parameter int bus_w           = 64,
  parameter int sample_w        = 32,
  parameter int cmd_depth       = 4,
  parameter int data_depth      = 16,
  parameter int max_outstanding = 4
) (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             flush,
  // Command in
  input  wire                             cmd_valid,
  output logic                            cmd_ready,
  input  wire [addr_w-1:0]                cmd_addr,
  input  wire [dma_cfg_pkg::len_w-1:0]    cmd_len,
  // Sample in
  input  wire                             data_valid,
  output logic                            data_ready,
  input  wire [sample_w-1:0]              data,
  // AXI write master
  output logic                            awvalid,
  input  wire                             awready,
  output logic [addr_w-1:0]               awaddr,
  output logic [dma_cfg_pkg::len_w-1:0]   awlen,
  output logic [axi_pkg::size_w-1:0]      awsize,
  output logic [axi_pkg::burst_w-1:0]     awburst,
  output logic                            wvalid,
  input  wire                             wready,
  output logic [bus_w-1:0]                wdata,
  output logic [bus_w/8-1:0]              wstrb,
  output logic                            wlast,
  input  wire                             bvalid,
  output logic                            bready,
  input  wire [axi_pkg::resp_w-1:0]       bresp,
  // Status
  output logic                            burst_done,
  output logic                            burst_error,
  output logic                            idle
);

  typedef struct packed {
    logic [addr_w-1:0]              addr;
    logic [dma_cfg_pkg::len_w-1:0]  len;
  } cmd_t;

  typedef logic [sample_w-1:0] smp_t;

  cmd_t  cmd_in;
  cmd_t  cmd_head;
  logic  head_valid;
  logic  head_pop;
  smp_t  smp_head;
  logic  smp_valid;
  logic  smp_pop;
  logic  aw_fire;
  logic  credit_ok;
  logic  issuer_busy;
  logic  outstanding_zero;

  assign cmd_in = '{addr: cmd_addr, len: cmd_len};

  // ****************************************
  // Command and sample queues
  // ****************************************
  sync_fifo #(.depth(cmd_depth), .payload_t(cmd_t)) u_cmd_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear    (flush),
    .push     (cmd_valid),
    .wr_ready (cmd_ready),
    .wr_data  (cmd_in),
    .pop      (head_pop),
    .rd_valid (head_valid),
    .rd_data  (cmd_head)
  );

  sync_fifo #(.depth(data_depth), .payload_t(smp_t)) u_data_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear    (flush),
    .push     (data_valid),
    .wr_ready (data_ready),
    .wr_data  (data),
    .pop      (smp_pop),
    .rd_valid (smp_valid),
    .rd_data  (smp_head)
  );

  axi_write_issuer #(
    .addr_w   (addr_w),
    .bus_w    (bus_w),
    .sample_w (sample_w)
  ) u_issuer (
    .clk        (clk),
    .rst_n      (rst_n),
    .head_valid (head_valid),
    .head_addr  (cmd_head.addr),
    .head_len   (cmd_head.len),
    .head_pop   (head_pop),
    .smp_valid  (smp_valid),
    .smp        (smp_head),
    .smp_pop    (smp_pop),
    .credit_ok  (credit_ok),
    .aw_fire    (aw_fire),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .awlen      (awlen),
    .awsize     (awsize),
    .awburst    (awburst),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wlast      (wlast),
    .busy       (issuer_busy)
  );

  write_resp_tracker #(.max_outstanding(max_outstanding)) u_tracker (
    .clk              (clk),
    .rst_n            (rst_n),
    .aw_fire          (aw_fire),
    .credit_ok        (credit_ok),
    .bvalid           (bvalid),
    .bready           (bready),
    .bresp            (bresp),
    .burst_done       (burst_done),
    .burst_error      (burst_error),
    .outstanding_zero (outstanding_zero)
  );

  // Nothing queued, no burst in its data phase, no response owed
  assign idle = !head_valid && !smp_valid && !issuer_busy && outstanding_zero;

endmodule

`default_nettype wire

// File: design/write_resp_tracker.sv
/*
  Tracks bursts whose address was sent but whose response has not come.
  The slave must not answer a burst before its AW handshake.
  SLVERR and DECERR both count as errors; EXOKAY does not.
*/

`timescale 1ns/1ps
`default_nettype none

module write_resp_tracker #(
  parameter int max_outstanding = 4
) (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         aw_fire,
  output logic                        credit_ok,
  input  wire                         bvalid,
  output logic                        bready,
  input  wire [axi_pkg::resp_w-1:0]   bresp,
  output logic                        burst_done,
  output logic                        burst_error,
  output logic                        outstanding_zero
);

  localparam int cnt_w = $clog2(max_outstanding + 1);

  logic [cnt_w-1:0] pending;
  logic             b_fire;
  logic             b_err;

  assign b_fire = bvalid && bready;

  // Both error codes have the upper bit set
  assign b_err = |(bresp & axi_pkg::resp_slverr);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      pending <= '0;
    else if (aw_fire && !b_fire)
      pending <= pending + 1'b1;
    else if (b_fire && !aw_fire)
      pending <= pending - 1'b1;
  end

  // One pulse per response in the cycle after the handshake
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      burst_done  <= 1'b0;
      burst_error <= 1'b0;
    end
    else
    begin
      burst_done  <= b_fire;
      burst_error <= b_fire && b_err;
    end
  end

  assign bready           = (pending != '0);
  assign credit_ok        = (pending < cnt_w'(max_outstanding));
  assign outstanding_zero = (pending == '0);

endmodule

`default_nettype wire

// File: design/axi_write_issuer.sv
/*
  Turns the head command and queued samples into AXI4 AW and W traffic.
  Assumes sample_w divides bus_w, bus_w is at least 16 and addresses are
  aligned to the sample size. Only the low bits of the command length that
  cover max_beats are issued. One burst is in the data phase at a time.
*/

`timescale 1ns/1ps
`default_nettype none

module axi_write_issuer #(
  parameter int addr_w   = 32,
  parameter int bus_w    = 64,
  parameter int sample_w = 32
) (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             head_valid,
  input  wire [addr_w-1:0]                head_addr,
  input  wire [dma_cfg_pkg::len_w-1:0]    head_len,
  output logic                            head_pop,
  input  wire                             smp_valid,
  input  wire [sample_w-1:0]              smp,
  output logic                            smp_pop,
  input  wire                             credit_ok,
  output logic                            aw_fire,
  output logic                            awvalid,
  input  wire                             awready,
  output logic [addr_w-1:0]               awaddr,
  output logic [dma_cfg_pkg::len_w-1:0]   awlen,
  output logic [axi_pkg::size_w-1:0]      awsize,
  output logic [axi_pkg::burst_w-1:0]     awburst,
  output logic                            wvalid,
  input  wire                             wready,
  output logic [bus_w-1:0]                wdata,
  output logic [bus_w/8-1:0]              wstrb,
  output logic                            wlast,
  output logic                            busy
);

  localparam int smp_bytes = sample_w / 8;
  localparam int strb_w    = bus_w / 8;
  localparam int off_w     = $clog2(strb_w);
  localparam int copies    = bus_w / sample_w;
  localparam int len_bits  = $clog2(dma_cfg_pkg::max_beats);

  // Strobe of a sample sitting in the lowest lane
  localparam logic [strb_w-1:0] lane_mask = strb_w'((1 << smp_bytes) - 1);

  typedef enum logic {st_addr, st_data} state_t;

  state_t           state;
  logic             w_fire;
  logic             last_beat;
  logic             first_beat;
  logic [off_w-1:0] seed_off;
  logic [off_w-1:0] beat_off;
  logic [off_w-1:0] cur_off;

  // ****************************************
  // Address phase
  // ****************************************

  // credit_ok only rises while AW waits, so awvalid stays up once raised
  assign awvalid  = (state == st_addr) && head_valid && credit_ok;
  assign aw_fire  = awvalid && awready;
  assign head_pop = aw_fire;

  assign awaddr  = head_addr;
  assign awlen   = dma_cfg_pkg::len_w'(head_len[len_bits-1:0]);
  assign awsize  = axi_pkg::size_of_bytes(smp_bytes);
  assign awburst = axi_pkg::burst_incr;

  // ****************************************
  // Data phase
  // ****************************************
  assign wvalid  = (state == st_data) && smp_valid;
  assign w_fire  = wvalid && wready;
  assign smp_pop = w_fire;
  assign wlast   = last_beat;

  // Narrow samples are copied onto every lane
  assign wdata = {copies{smp}};

  // First beat takes its lane from the start address, later beats advance
  assign cur_off = first_beat ? seed_off : beat_off;
  assign wstrb   = lane_mask << cur_off;

  always_ff @(posedge clk)
  begin
    if (aw_fire)
      seed_off <= head_addr[off_w-1:0];
    // Lane offset wraps within the bus word
    if (w_fire)
      beat_off <= cur_off + off_w'(smp_bytes);
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state <= st_addr;
    else
    begin
      case (state)
        st_addr:
          if (aw_fire)
            state <= st_data;
        st_data:
          if (w_fire && last_beat)
            state <= st_addr;
        default:
          state <= st_addr;
      endcase
    end
  end

  assign busy = (state == st_data);

  beat_counter u_beat_counter (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (aw_fire),
    .step       (w_fire),
    .len        (awlen),
    .last_beat  (last_beat),
    .first_beat (first_beat)
  );

endmodule

`default_nettype wire

// File: design/beat_counter.sv
/*
  Beat counter for one burst. start loads the length (beats minus one)
  and clears the count; step counts one accepted beat.
  step must not arrive after the last beat of a burst.
*/

`timescale 1ns/1ps
`default_nettype none

module beat_counter (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            start,
  input  wire                            step,
  input  wire [dma_cfg_pkg::len_w-1:0]   len,
  output logic                           last_beat,
  output logic                           first_beat
);

  logic [dma_cfg_pkg::len_w-1:0] len_q;
  logic [dma_cfg_pkg::len_w-1:0] cnt;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      len_q <= '0;
      cnt   <= '0;
    end
    else if (start)
    begin
      // New burst restarts the count at beat zero
      len_q <= len;
      cnt   <= '0;
    end
    else if (step)
    begin
      cnt <= cnt + 1'b1;
    end
  end

  // Beat number cnt is the one on the bus now
  assign last_beat  = (cnt == len_q);
  assign first_beat = (cnt == '0);

endmodule

`default_nettype wire

// File: design/sync_fifo.sv
/*
  Single-clock show-ahead FIFO. The head is valid without a pop.
  Push and pop may happen in the same cycle; a push while full is ignored.
  clear empties the FIFO without touching the storage.
*/

`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int  depth     = 4,
  parameter type payload_t = logic [7:0]
) (
  input  wire      clk,
  input  wire      rst_n,
  input  wire      clear,
  input  wire      push,
  output logic     wr_ready,
  input  payload_t wr_data,
  input  wire      pop,
  output logic     rd_valid,
  output payload_t rd_data
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t           mem [depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [cnt_w-1:0]   count;
  logic               do_push;
  logic               do_pop;

  assign wr_ready = (count != cnt_w'(depth));
  assign rd_valid = (count != '0);
  assign rd_data  = mem[rd_ptr];

  assign do_push = push && wr_ready;
  assign do_pop  = pop && rd_valid;

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= wr_data;
  end

  // ****************************************
  // Pointers and occupancy
  // ****************************************
  always_ff @(posedge clk)
  begin
    if (!rst_n || clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      // Simultaneous push and pop leave the count unchanged
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/axi_pkg.sv
/*
  AXI4 field widths and encodings used by the write master.
  Only the fields of a single-ID INCR write path are defined.
*/

`default_nettype none

package axi_pkg;

  // Field widths
  localparam int burst_w = 2;
  localparam int size_w  = 3;
  localparam int resp_w  = 2;

  // Burst type
  localparam logic [burst_w-1:0] burst_incr = 2'b01;

  // Response codes
  localparam logic [resp_w-1:0] resp_okay   = 2'b00;
  localparam logic [resp_w-1:0] resp_slverr = 2'b10;

  // Maps a beat size in bytes to the AxSIZE code
  // nbytes must be a power of two from 1 to 128
  function automatic logic [size_w-1:0] size_of_bytes(input int unsigned nbytes);
    return size_w'($clog2(nbytes));
  endfunction

endpackage

`default_nettype wire

// File: design/dma_cfg_pkg.sv
/*
  Engine-wide sizes of the DMA write engine.
  Command lengths follow the AXI convention (beats minus one).
  Bursts longer than max_beats are outside the engine's range.
*/

`default_nettype none

package dma_cfg_pkg;

  // ****************************************
  // Command fields
  // ****************************************

  // Beat count field of a command in AXI awlen encoding
  localparam int len_w = 8;

  // ****************************************
  // Engine limits
  // ****************************************

  // Largest burst the engine issues, in beats
  localparam int max_beats = 16;

endpackage

`default_nettype wire
